//--- hdl/ws2812_pkg.sv
package ws2812_pkg;

    localparam int ADDR_W       = 6;     // one pixel address
    localparam int COLOR_W      = 24;    // bits per pixel on the wire

    localparam int BIT_CYCLES   = 62;    // 1.24 us at 50 MHz
    localparam int T0H_CYCLES   = 20;    // 0.40 us high for a zero
    localparam int T1H_CYCLES   = 40;    // 0.80 us high for a one
    localparam int RESET_CYCLES = 2600;  // 52 us latch code

    localparam int BIT_CNT_W    = $clog2(BIT_CYCLES);
    localparam int RST_CNT_W    = $clog2(RESET_CYCLES);
    localparam int IDX_W        = $clog2(COLOR_W);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_READ     = 2'd1;
    localparam logic [1:0] ST_SEND_BIT = 2'd2;
    localparam logic [1:0] ST_SEND_RST = 2'd3;

    // one stored word, seen as decoded fields by the sequencer
    // and as four byte lanes by the memory write port
    typedef union packed {
        struct packed {
            logic [1:0]        spare;
            logic [ADDR_W-1:0] link;   // 0 ends the chain
            logic [7:0]        green;
            logic [7:0]        red;
            logic [7:0]        blue;
        } fields;
        logic [3:0][7:0] lanes;        // lane 3 link, 2 green, 1 red, 0 blue
    } pixel_word_t;

endpackage

//--- hdl/pixel_ram.sv
`timescale 1ns/10ps

module pixel_ram
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [3:0]        byte_en,
    input  logic [7:0]        byte_data,

    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output pixel_word_t       q
);

    pixel_word_t mem [0:(1 << ADDR_W) - 1];

    // byte_data lands in every enabled lane
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[wr_addr].lanes[i] <= byte_data;
                end
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            q <= '0;
        end else if (rd_en) begin
            q <= mem[rd_addr];   // old data on a same-address write
        end
    end

endmodule

//--- hdl/ws2812_bit.sv
`timescale 1ns/10ps

module ws2812_bit
    import ws2812_pkg::*;
(
    input  logic clk_in,
    input  logic rst_n_in,

    input  logic bit_rdy,
    input  logic bit_data,

    output logic dout,
    output logic bit_done
);

    logic                 active;      // bit period in progress
    logic [BIT_CNT_W-1:0] cnt;         // cycles since bit_rdy
    logic [BIT_CNT_W-1:0] high_time;

    always_ff @(posedge clk_in) begin
        if (bit_rdy) begin
            high_time <= bit_data ? BIT_CNT_W'(T1H_CYCLES) : BIT_CNT_W'(T0H_CYCLES);
        end
    end

    // period runs from bit_rdy to the next bit_rdy, BIT_CYCLES apart
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            active   <= 1'b0;
            cnt      <= '0;
            dout     <= 1'b0;
            bit_done <= 1'b0;
        end else begin
            bit_done <= active && (cnt == BIT_CNT_W'(BIT_CYCLES - 2));

            if (bit_rdy) begin
                active <= 1'b1;
                cnt    <= BIT_CNT_W'(1);
                dout   <= 1'b1;              // high from the next cycle
            end else if (active) begin
                cnt  <= cnt + 1'b1;
                dout <= (cnt < high_time);
                if (cnt == BIT_CNT_W'(BIT_CYCLES - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |-> !active);

    // line must rest low between bits and during the latch code
    a_idle_low: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        !active |-> !dout);

endmodule

//--- hdl/ws2812_ctl.sv
`timescale 1ns/10ps

module ws2812_ctl
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              frame_rdy,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [3:0]        byte_en,
    input  logic [7:0]        byte_data,

    input  logic              bit_done,
    output logic              bit_rdy,
    output logic              bit_data,
    output logic              busy
);

    logic [1:0]           state;
    logic [1:0]           rd_phase;   // strobe, data, register
    logic                 frame_q;

    logic                 rd_en;
    logic [ADDR_W-1:0]    rd_addr;
    pixel_word_t          q;

    logic [ADDR_W-1:0]    link;
    logic [COLOR_W-1:0]   colour;     // g, r, b in wire order
    logic [IDX_W-1:0]     bit_idx;
    logic [RST_CNT_W-1:0] rst_cnt;

    wire start  = frame_rdy && !frame_q;                     // rising edge only
    wire launch = (state == ST_READ) && (rd_phase == 2'd2);  // self strobe for bit 23
    wire step   = (state == ST_SEND_BIT) && bit_done;

    assign rd_en    = (state == ST_READ) && (rd_phase == 2'd0);
    assign busy     = (state != ST_IDLE);
    assign bit_data = colour[bit_idx];

    pixel_ram u_ram (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .byte_en   (byte_en),
        .byte_data (byte_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .q         (q)
    );

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            frame_q <= 1'b0;
        end else begin
            frame_q <= frame_rdy;
        end
    end

    always_ff @(posedge clk_in) begin
        if ((state == ST_READ) && (rd_phase == 2'd1)) begin
            link   <= q.fields.link;
            colour <= {q.fields.green, q.fields.red, q.fields.blue};
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state    <= ST_IDLE;
            rd_phase <= 2'd0;
            rd_addr  <= '0;
            bit_idx  <= '0;
            rst_cnt  <= '0;
            bit_rdy  <= 1'b0;
        end else begin
            bit_rdy <= launch || (step && (bit_idx != '0));

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_READ;
                        rd_phase <= 2'd0;
                        rd_addr  <= '0;     // every frame begins at word 0
                    end
                end
                ST_READ: begin
                    rd_phase <= rd_phase + 2'd1;
                    if (launch) begin
                        state   <= ST_SEND_BIT;
                        bit_idx <= IDX_W'(COLOR_W - 1);
                    end
                end
                ST_SEND_BIT: begin
                    if (step) begin
                        if (bit_idx != '0) begin
                            bit_idx <= bit_idx - 1'b1;
                        end else if (link == '0) begin
                            state   <= ST_SEND_RST;
                            rst_cnt <= '0;
                        end else begin
                            state    <= ST_READ;
                            rd_phase <= 2'd0;
                            rd_addr  <= link;   // follow the chain
                        end
                    end
                end
                ST_SEND_RST: begin
                    if (rst_cnt == RST_CNT_W'(RESET_CYCLES - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // every state change follows one of the sequencer arcs
    a_state_legal: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        (state != $past(state)) |->
            (((state == ST_READ) &&
              (($past(state) == ST_IDLE) || ($past(state) == ST_SEND_BIT))) ||
             ((state == ST_SEND_BIT) && ($past(state) == ST_READ)) ||
             ((state == ST_SEND_RST) && ($past(state) == ST_SEND_BIT)) ||
             ((state == ST_IDLE) && ($past(state) == ST_SEND_RST))));

    // the encoder is only ever launched from the send state
    a_rdy_in_send: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |-> (state == ST_SEND_BIT));

    a_idx_range: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        bit_idx <= IDX_W'(COLOR_W - 1));

endmodule

//--- hdl/ws2812_top.sv
`timescale 1ns/10ps

module ws2812_top
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [3:0]        byte_en,
    input  logic [7:0]        byte_data,

    input  logic              frame_rdy,

    output logic              dout,
    output logic              busy
);

    logic bit_rdy;
    logic bit_data;
    logic bit_done;

    ws2812_ctl u_ctl (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .frame_rdy (frame_rdy),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .byte_en   (byte_en),
        .byte_data (byte_data),
        .bit_done  (bit_done),
        .bit_rdy   (bit_rdy),
        .bit_data  (bit_data),
        .busy      (busy)
    );

    ws2812_bit u_bit (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .bit_rdy  (bit_rdy),
        .bit_data (bit_data),
        .dout     (dout),
        .bit_done (bit_done)
    );

endmodule

//--- verification/ws2812_tb.sv
`timescale 1ns/10ps

module ws2812_tb
    import ws2812_pkg::*;
();

    logic              clk_in;
    logic              rst_n_in;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [3:0]        byte_en;
    logic [7:0]        byte_data;
    logic              frame_rdy;
    logic              dout;
    logic              busy;

    logic [31:0]        model_mem [64];   // what the pixel memory should hold
    logic [31:0]        rng;
    logic               started;          // first frame_rdy has been driven
    logic [COLOR_W-1:0] rx_pixels [$];

    // pulse decoder state
    logic               dout_q;
    logic               rx_bit;
    logic [COLOR_W-1:0] shift_reg;
    int                 high_len;
    int                 bits_in_pixel;
    int                 cycle_no;
    int                 last_rise;

    int                 low_cnt;          // consecutive low samples of dout
    logic               busy_q;

    ws2812_top DUT (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .byte_en   (byte_en),
        .byte_data (byte_data),
        .frame_rdy (frame_rdy),
        .dout      (dout),
        .busy      (busy)
    );

    always #10 clk_in = ~clk_in;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        stop_with_failure($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                    test, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_colour(output logic [COLOR_W-1:0] colour);
        rng    = xorshift32(rng);
        colour = rng[COLOR_W-1:0];
    endtask

    // one byte write that stays on the bus until the next write or end_writes
    task automatic write_lanes(input logic [ADDR_W-1:0] addr, input logic [3:0] lanes,
                               input logic [7:0] data);
        @(negedge clk_in);
        wr_en     = 1'b1;
        wr_addr   = addr;
        byte_en   = lanes;
        byte_data = data;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                model_mem[addr][8*i +: 8] = data;
            end
        end
    endtask

    task automatic end_writes();
        @(negedge clk_in);
        wr_en   = 1'b0;
        byte_en = 4'b0000;
    endtask

    task automatic write_pixel(input logic [ADDR_W-1:0] addr, input logic [ADDR_W-1:0] link,
                               input logic [COLOR_W-1:0] colour);
        write_lanes(addr, 4'b1000, {2'b00, link});
        write_lanes(addr, 4'b0100, colour[23:16]);   // green
        write_lanes(addr, 4'b0010, colour[15:8]);    // red
        write_lanes(addr, 4'b0001, colour[7:0]);     // blue
        end_writes();
    endtask

    // start a frame, optionally pulse frame_rdy again mid frame, then compare pixels
    task automatic run_frame(input string test, input bit poke_busy);
        logic [COLOR_W-1:0] expected [$];
        logic [ADDR_W-1:0]  addr;
        addr = '0;
        for (int n = 0; n < 64; n++) begin
            expected.push_back(model_mem[addr][COLOR_W-1:0]);
            addr = model_mem[addr][29:24];
            if (addr == '0) begin
                break;
            end
        end
        rx_pixels.delete();

        @(negedge clk_in);
        frame_rdy = 1'b1;
        started   = 1'b1;
        @(negedge clk_in);
        frame_rdy = 1'b0;
        assert (busy) else stop_with_failure($sformatf("%s: busy did not rise after frame_rdy",
                                                       test));
        if (poke_busy) begin
            repeat (30 * BIT_CYCLES) @(negedge clk_in);   // well inside the second pixel
            frame_rdy = 1'b1;
            @(negedge clk_in);
            frame_rdy = 1'b0;
        end
        while (busy) @(negedge clk_in);

        assert (rx_pixels.size() == expected.size())
            else report_mismatch({test, " pixel count"}, expected.size(), rx_pixels.size());
        foreach (expected[i]) begin
            assert (rx_pixels[i] == expected[i])
                else report_mismatch($sformatf("%s pixel %0d", test, i),
                                     int'(expected[i]), int'(rx_pixels[i]));
        end
    endtask

    // measure each high pulse of dout in clock cycles
    always @(posedge clk_in) begin
        cycle_no = cycle_no + 1;
        if (rst_n_in) begin
            if (dout && !dout_q) begin
                if (bits_in_pixel != 0) begin
                    assert (cycle_no - last_rise == BIT_CYCLES)
                        else report_mismatch("bit_spacing", BIT_CYCLES, cycle_no - last_rise);
                end
                last_rise = cycle_no;
            end
            if (dout) begin
                high_len = high_len + 1;
            end else if (high_len != 0) begin
                if (high_len == T1H_CYCLES) begin
                    rx_bit = 1'b1;
                end else if (high_len == T0H_CYCLES) begin
                    rx_bit = 1'b0;
                end else begin
                    stop_with_failure($sformatf("dout pulse of %0d cycles is not a valid bit",
                                                high_len));
                end
                shift_reg     = {shift_reg[COLOR_W-2:0], rx_bit};   // msb arrives first
                bits_in_pixel = bits_in_pixel + 1;
                high_len      = 0;
                if (bits_in_pixel == COLOR_W) begin
                    rx_pixels.push_back(shift_reg);
                    bits_in_pixel = 0;
                end
            end
            dout_q = dout;
        end
    end

    always @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            low_cnt <= 0;
            busy_q  <= 1'b0;
        end else begin
            busy_q <= busy;
            if (busy_q && !busy) begin   // end of frame
                assert (low_cnt >= RESET_CYCLES)
                    else report_mismatch("reset_gap", RESET_CYCLES, low_cnt);
            end
            if (dout) begin
                low_cnt <= 0;
            end else if (low_cnt < 100000) begin
                low_cnt <= low_cnt + 1;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        !started |-> (!dout && !busy))
        else stop_with_failure("dout or busy went high before the first frame_rdy");

    line_needs_busy: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        dout |-> busy)
        else stop_with_failure("dout was high while busy was low");

    // a pulse during a frame must not start another one
    start_needs_pulse: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        $rose(busy) |-> $past(frame_rdy))
        else stop_with_failure("busy rose without a frame_rdy pulse");

    initial begin : watchdog
        int frame_pixels [4];
        int limit;
        frame_pixels = '{1, 3, 3, 3};
        limit = 0;
        foreach (frame_pixels[i]) begin
            limit += frame_pixels[i] * COLOR_W * BIT_CYCLES + RESET_CYCLES + 100;
        end
        repeat (limit) @(posedge clk_in);
        stop_with_failure("watchdog expired before the tests finished");
    end

    initial begin : stimulus
        logic [COLOR_W-1:0] colour;
        clk_in        = 1'b0;
        rst_n_in      = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        byte_en       = 4'b0000;
        byte_data     = 8'h00;
        frame_rdy     = 1'b0;
        started       = 1'b0;
        rng           = 32'hcfd1_449a;
        dout_q        = 1'b0;
        shift_reg     = '0;
        high_len      = 0;
        bits_in_pixel = 0;
        cycle_no      = 0;
        last_rise     = 0;
        repeat (10) @(negedge clk_in);
        rst_n_in = 1'b1;

        repeat (20) @(negedge clk_in);   // quiet line after reset

        next_colour(colour);
        write_pixel(6'd0, 6'd0, colour);
        run_frame("single_pixel", 1'b0);

        // chain 0 -> 5 -> 17 with unreachable words around it
        next_colour(colour);
        write_pixel(6'd1, 6'd0, colour);
        next_colour(colour);
        write_pixel(6'd9, 6'd17, colour);
        next_colour(colour);
        write_pixel(6'd17, 6'd0, colour);
        next_colour(colour);
        write_pixel(6'd5, 6'd17, colour);
        next_colour(colour);
        write_pixel(6'd0, 6'd5, colour);
        run_frame("linked_chain", 1'b0);

        write_lanes(6'd5, 4'b0010, model_mem[5][15:8] ^ 8'ha5);   // red lane only
        end_writes();
        run_frame("byte_enable", 1'b0);

        run_frame("start_while_busy", 1'b1);
        repeat (20) @(negedge clk_in);   // no late restart

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- all.f
hdl/ws2812_pkg.sv
hdl/pixel_ram.sv
hdl/ws2812_bit.sv
hdl/ws2812_ctl.sv
hdl/ws2812_top.sv
verification/ws2812_tb.sv

//--- Makefile
# Verilator flow for the WS2812 chain driver
# override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= ws2812_tb
RTL_TOP    ?= ws2812_top
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing --assert
EXTRA      ?=

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter hdl/%,$(SOURCES))
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) \
		-f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
